// File: rtl/memgame_pkg.sv
package memgame_pkg;

    // Plain vector types
    typedef logic [9:0]  coord_t;
    typedef logic [3:0]  tile_idx_t;
    typedef logic [15:0] tile_vec_t;
    typedef logic [12:0] pix_addr_t;
    typedef logic [11:0] rgb_t;
    typedef logic [7:0]  scan_code_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHOW,
        ST_PLAY,
        ST_FINISH
    } game_state_t;

    // 640x480 at 60 Hz, counted in pixel clocks
    localparam int H_DISPLAY = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int H_TOTAL   = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;

    localparam int V_DISPLAY = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;
    localparam int V_TOTAL   = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;

    // Source image size, shown at twice the size on screen
    localparam int TILE_W = 80;
    localparam int TILE_H = 60;

    localparam int NUM_TILES    = 16;
    localparam int NUM_PAIRS    = 8;
    localparam int DEBOUNCE_LEN = 7;

    localparam scan_code_t SC_SHIFT = 8'h12;
    localparam scan_code_t SC_ENTER = 8'h5A;

    // Keys 1 2 3 4 / Q W E R / A S D F / Z X C V
    localparam scan_code_t TILE_SCAN_CODES [NUM_TILES] = '{
        8'h16, 8'h1E, 8'h26, 8'h25,
        8'h15, 8'h1D, 8'h24, 8'h2D,
        8'h1C, 8'h1B, 8'h23, 8'h2B,
        8'h1A, 8'h22, 8'h21, 8'h2A
    };

    // Tiles 0, 1, 13 and 14 start upside down
    localparam tile_vec_t INIT_FLIP = 16'b0110_0000_0000_0011;

endpackage

// File: rtl/button_pulse.sv
`timescale 1ns/100ps

module button_pulse (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic pulse_o
);

    logic [memgame_pkg::DEBOUNCE_LEN-1:0] samples;
    logic level;
    logic level_d;

    // Stable only once every sample in the window is high
    assign level = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
            level_d <= 1'b0;
            pulse_o <= 1'b0;
        end else begin
            samples <= {samples[memgame_pkg::DEBOUNCE_LEN-2:0], btn_i};
            level_d <= level;
            // One pulse per press, none while held
            pulse_o <= level & ~level_d;
        end
    end

endmodule

// File: rtl/key_tracker.sv
`timescale 1ns/100ps

module key_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   key_valid_i,
    input  memgame_pkg::scan_code_t key_code_i,
    input  logic                   key_break_i,
    output logic                   cmd_enter_o,
    output logic                   cmd_flip_o,
    output memgame_pkg::tile_idx_t flip_tile_o,
    output logic                   cmd_pair_o,
    output memgame_pkg::tile_idx_t first_tile_o,
    output memgame_pkg::tile_idx_t second_tile_o
);

    // Tile keys in the low bits, then shift, then enter
    typedef logic [memgame_pkg::NUM_TILES+1:0] key_vec_t;

    function automatic key_vec_t key_mask(input memgame_pkg::scan_code_t code);
        key_vec_t mask;
        mask = '0;
        for (int i = 0; i < memgame_pkg::NUM_TILES; i++) begin
            mask[i] = (code == memgame_pkg::TILE_SCAN_CODES[i]);
        end
        mask[memgame_pkg::NUM_TILES]   = (code == memgame_pkg::SC_SHIFT);
        mask[memgame_pkg::NUM_TILES+1] = (code == memgame_pkg::SC_ENTER);
        return mask;
    endfunction

    function automatic memgame_pkg::tile_idx_t tile_of(input key_vec_t mask);
        memgame_pkg::tile_idx_t idx;
        idx = '0;
        for (int i = 0; i < memgame_pkg::NUM_TILES; i++) begin
            if (mask[i]) begin
                idx = memgame_pkg::tile_idx_t'(i);
            end
        end
        return idx;
    endfunction

    key_vec_t                held;
    key_vec_t                cur_mask;
    key_vec_t                prev_mask;
    memgame_pkg::scan_code_t prev_code;
    logic                    prev_valid;
    logic                    prev_held;
    logic                    make;

    assign cur_mask  = key_mask(key_code_i);
    assign prev_mask = key_mask(prev_code);
    assign make      = key_valid_i && !key_break_i && (|cur_mask);
    // Previous key still down and different from the new one
    assign prev_held = prev_valid && (|(held & prev_mask)) && (prev_code != key_code_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held        <= '0;
            prev_code   <= '0;
            prev_valid  <= 1'b0;
            cmd_enter_o <= 1'b0;
            cmd_flip_o  <= 1'b0;
            cmd_pair_o  <= 1'b0;
        end else begin
            cmd_enter_o <= 1'b0;
            cmd_flip_o  <= 1'b0;
            cmd_pair_o  <= 1'b0;
            if (key_valid_i && key_break_i) begin
                held <= held & ~cur_mask;
                if (key_code_i == prev_code) begin
                    prev_valid <= 1'b0;
                end
            end else if (make) begin
                held       <= held | cur_mask;
                prev_code  <= key_code_i;
                prev_valid <= 1'b1;
                if (cur_mask[memgame_pkg::NUM_TILES+1]) begin
                    cmd_enter_o <= 1'b1;
                end else if (prev_held) begin
                    if (cur_mask[memgame_pkg::NUM_TILES]) begin
                        cmd_flip_o <= |prev_mask[memgame_pkg::NUM_TILES-1:0];
                    end else if (prev_mask[memgame_pkg::NUM_TILES]) begin
                        cmd_flip_o <= |cur_mask[memgame_pkg::NUM_TILES-1:0];
                    end else begin
                        cmd_pair_o <= (|prev_mask[memgame_pkg::NUM_TILES-1:0]) &&
                                      (|cur_mask[memgame_pkg::NUM_TILES-1:0]);
                    end
                end
            end
        end
    end

    // Tile numbers latched on every make event
    always_ff @(posedge clk) begin
        if (make) begin
            flip_tile_o   <= cur_mask[memgame_pkg::NUM_TILES] ? tile_of(prev_mask)
                                                              : tile_of(cur_mask);
            first_tile_o  <= tile_of(prev_mask);
            second_tile_o <= tile_of(cur_mask);
        end
    end

endmodule

// File: rtl/board_ctrl.sv
`timescale 1ns/100ps

module board_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_pulse_i,
    input  logic                     hint_i,
    input  logic                     cmd_enter_i,
    input  logic                     cmd_flip_i,
    input  memgame_pkg::tile_idx_t   flip_tile_i,
    input  logic                     cmd_pair_i,
    input  memgame_pkg::tile_idx_t   first_tile_i,
    input  memgame_pkg::tile_idx_t   second_tile_i,
    output memgame_pkg::tile_vec_t   shown_o,
    output memgame_pkg::tile_vec_t   matched_o,
    output memgame_pkg::tile_vec_t   flip_o,
    output memgame_pkg::game_state_t state_o,
    output logic                     pass_o
);

    logic       ready;
    logic [3:0] match_cnt;
    logic       flip_ok;
    logic       pair_ok;
    logic       same_image;
    logic       is_match;

    assign flip_ok = ready && !matched_o[flip_tile_i];
    assign pair_ok = ready && !matched_o[first_tile_i] && !matched_o[second_tile_i];

    // Tile i carries image i mod 8
    assign same_image = (first_tile_i % memgame_pkg::NUM_PAIRS) ==
                        (second_tile_i % memgame_pkg::NUM_PAIRS);
    assign is_match   = same_image && !flip_o[first_tile_i] && !flip_o[second_tile_i];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_o   <= memgame_pkg::ST_IDLE;
            shown_o   <= '0;
            matched_o <= '0;
            flip_o    <= '0;
            ready     <= 1'b1;
            match_cnt <= '0;
            pass_o    <= 1'b0;
        end else begin
            case (state_o)
                memgame_pkg::ST_IDLE: begin
                    shown_o   <= '0;
                    matched_o <= '0;
                    flip_o    <= '0;
                    ready     <= 1'b1;
                    match_cnt <= '0;
                    pass_o    <= 1'b0;
                    if (start_pulse_i) begin
                        // Show state opens with every tile up and the initial flip set
                        state_o <= memgame_pkg::ST_SHOW;
                        shown_o <= '1;
                        flip_o  <= memgame_pkg::INIT_FLIP;
                    end
                end
                memgame_pkg::ST_SHOW: begin
                    if (start_pulse_i) begin
                        state_o <= memgame_pkg::ST_PLAY;
                        shown_o <= '0;
                    end
                end
                memgame_pkg::ST_PLAY: begin
                    if (match_cnt == memgame_pkg::NUM_PAIRS) begin
                        state_o <= memgame_pkg::ST_FINISH;
                    end else if (!hint_i) begin
                        if (cmd_enter_i) begin
                            // Hide whatever is open but not yet solved
                            shown_o <= shown_o & matched_o;
                            ready   <= 1'b1;
                        end else if (cmd_flip_i && flip_ok) begin
                            shown_o[flip_tile_i] <= 1'b1;
                            flip_o[flip_tile_i]  <= ~flip_o[flip_tile_i];
                            ready                <= 1'b0;
                        end else if (cmd_pair_i && pair_ok) begin
                            shown_o[first_tile_i]  <= 1'b1;
                            shown_o[second_tile_i] <= 1'b1;
                            ready                  <= 1'b0;
                            if (is_match) begin
                                matched_o[first_tile_i]  <= 1'b1;
                                matched_o[second_tile_i] <= 1'b1;
                                match_cnt                <= match_cnt + 4'd1;
                            end
                        end
                    end
                end
                memgame_pkg::ST_FINISH: begin
                    pass_o  <= 1'b1;
                    shown_o <= '1;
                    if (start_pulse_i) begin
                        state_o <= memgame_pkg::ST_IDLE;
                        pass_o  <= 1'b0;
                    end
                end
                default: begin
                    state_o <= memgame_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/vga_timing.sv
`timescale 1ns/100ps

module vga_timing (
    input  logic                clk,
    input  logic                rst,
    output memgame_pkg::coord_t h_cnt_o,
    output memgame_pkg::coord_t v_cnt_o,
    output logic                active_o,
    output logic                hsync_o,
    output logic                vsync_o
);

    memgame_pkg::coord_t h_cnt;
    memgame_pkg::coord_t v_cnt;
    memgame_pkg::coord_t h_next;
    memgame_pkg::coord_t v_next;
    logic                line_end;

    assign line_end = (h_cnt == memgame_pkg::H_TOTAL - 1);
    assign h_next   = line_end ? '0 : h_cnt + 10'd1;
    assign v_next   = !line_end ? v_cnt :
                      (v_cnt == memgame_pkg::V_TOTAL - 1) ? '0 : v_cnt + 10'd1;

    // Syncs are decoded from the next count so they line up with it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            h_cnt   <= h_next;
            v_cnt   <= v_next;
            hsync_o <= !((h_next >= memgame_pkg::H_DISPLAY + memgame_pkg::H_FRONT) &&
                         (h_next < memgame_pkg::H_DISPLAY + memgame_pkg::H_FRONT +
                                   memgame_pkg::H_SYNC));
            vsync_o <= !((v_next >= memgame_pkg::V_DISPLAY + memgame_pkg::V_FRONT) &&
                         (v_next < memgame_pkg::V_DISPLAY + memgame_pkg::V_FRONT +
                                   memgame_pkg::V_SYNC));
        end
    end

    assign active_o = (h_cnt < memgame_pkg::H_DISPLAY) && (v_cnt < memgame_pkg::V_DISPLAY);

    // Blanking reads as zero
    assign h_cnt_o = (h_cnt < memgame_pkg::H_DISPLAY) ? h_cnt : '0;
    assign v_cnt_o = (v_cnt < memgame_pkg::V_DISPLAY) ? v_cnt : '0;

endmodule

// File: rtl/tile_render.sv
`timescale 1ns/100ps

module tile_render (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hint_i,
    input  memgame_pkg::coord_t    h_cnt_i,
    input  memgame_pkg::coord_t    v_cnt_i,
    input  logic                   active_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  memgame_pkg::tile_vec_t visible_i,
    input  memgame_pkg::tile_vec_t flip_i,
    input  memgame_pkg::rgb_t      pixel_data_i,
    output memgame_pkg::tile_idx_t tile_o,
    output memgame_pkg::pix_addr_t pixel_addr_o,
    output memgame_pkg::rgb_t      rgb_o,
    output logic                   hsync_o,
    output logic                   vsync_o
);

    memgame_pkg::coord_t x;
    memgame_pkg::coord_t y;
    memgame_pkg::coord_t grid_col;
    memgame_pkg::coord_t grid_row;
    memgame_pkg::coord_t img_x;
    memgame_pkg::coord_t row_in_tile;
    memgame_pkg::coord_t img_y;
    logic                show_q;

    // Each source pixel covers 2x2 screen pixels
    assign x = h_cnt_i >> 1;
    assign y = v_cnt_i >> 1;

    assign grid_col = memgame_pkg::coord_t'(x / memgame_pkg::TILE_W);
    assign grid_row = memgame_pkg::coord_t'(y / memgame_pkg::TILE_H);
    assign tile_o   = {grid_row[1:0], grid_col[1:0]};

    assign img_x       = x - memgame_pkg::coord_t'(grid_col * memgame_pkg::TILE_W);
    assign row_in_tile = y - memgame_pkg::coord_t'(grid_row * memgame_pkg::TILE_H);

    // Upside-down tiles read their rows bottom first, except under hint
    assign img_y = (flip_i[tile_o] && !hint_i) ?
                   memgame_pkg::coord_t'(memgame_pkg::TILE_H - 1) - row_in_tile :
                   row_in_tile;

    assign pixel_addr_o = memgame_pkg::pix_addr_t'(img_y) *
                          memgame_pkg::pix_addr_t'(memgame_pkg::TILE_W) +
                          memgame_pkg::pix_addr_t'(img_x);

    // One stage to match the image memory latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            show_q  <= 1'b0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            show_q  <= active_i && (visible_i[tile_o] || hint_i);
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
        end
    end

    assign rgb_o = show_q ? pixel_data_i : '0;

endmodule

// File: rtl/memgame_top.sv
`timescale 1ns/100ps

module memgame_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_i,
    input  logic                     hint_i,
    input  logic                     key_valid_i,
    input  memgame_pkg::scan_code_t  key_code_i,
    input  logic                     key_break_i,
    input  memgame_pkg::rgb_t        pixel_data_i,
    output logic                     hsync_o,
    output logic                     vsync_o,
    output memgame_pkg::rgb_t        rgb_o,
    output memgame_pkg::pix_addr_t   pixel_addr_o,
    output memgame_pkg::tile_idx_t   tile_o,
    output memgame_pkg::tile_vec_t   shown_o,
    output memgame_pkg::tile_vec_t   matched_o,
    output memgame_pkg::game_state_t state_o,
    output logic                     pass_o
);

    logic                   start_pulse;
    logic                   cmd_enter;
    logic                   cmd_flip;
    logic                   cmd_pair;
    memgame_pkg::tile_idx_t flip_tile;
    memgame_pkg::tile_idx_t first_tile;
    memgame_pkg::tile_idx_t second_tile;
    memgame_pkg::tile_vec_t flip_vec;
    memgame_pkg::tile_vec_t visible;
    memgame_pkg::coord_t    h_cnt;
    memgame_pkg::coord_t    v_cnt;
    logic                   active;
    logic                   hsync;
    logic                   vsync;

    // Matched tiles stay up even after Enter
    assign visible = shown_o | matched_o;

    button_pulse u_start (
        .clk     (clk),
        .rst     (rst),
        .btn_i   (start_i),
        .pulse_o (start_pulse)
    );

    key_tracker u_keys (
        .clk           (clk),
        .rst           (rst),
        .key_valid_i   (key_valid_i),
        .key_code_i    (key_code_i),
        .key_break_i   (key_break_i),
        .cmd_enter_o   (cmd_enter),
        .cmd_flip_o    (cmd_flip),
        .flip_tile_o   (flip_tile),
        .cmd_pair_o    (cmd_pair),
        .first_tile_o  (first_tile),
        .second_tile_o (second_tile)
    );

    board_ctrl u_board (
        .clk           (clk),
        .rst           (rst),
        .start_pulse_i (start_pulse),
        .hint_i        (hint_i),
        .cmd_enter_i   (cmd_enter),
        .cmd_flip_i    (cmd_flip),
        .flip_tile_i   (flip_tile),
        .cmd_pair_i    (cmd_pair),
        .first_tile_i  (first_tile),
        .second_tile_i (second_tile),
        .shown_o       (shown_o),
        .matched_o     (matched_o),
        .flip_o        (flip_vec),
        .state_o       (state_o),
        .pass_o        (pass_o)
    );

    vga_timing u_vga (
        .clk      (clk),
        .rst      (rst),
        .h_cnt_o  (h_cnt),
        .v_cnt_o  (v_cnt),
        .active_o (active),
        .hsync_o  (hsync),
        .vsync_o  (vsync)
    );

    tile_render u_render (
        .clk          (clk),
        .rst          (rst),
        .hint_i       (hint_i),
        .h_cnt_i      (h_cnt),
        .v_cnt_i      (v_cnt),
        .active_i     (active),
        .hsync_i      (hsync),
        .vsync_i      (vsync),
        .visible_i    (visible),
        .flip_i       (flip_vec),
        .pixel_data_i (pixel_data_i),
        .tile_o       (tile_o),
        .pixel_addr_o (pixel_addr_o),
        .rgb_o        (rgb_o),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o)
    );

endmodule

// File: tests/memgame_tb.sv
`timescale 1ns/100ps

module memgame_tb;

    logic                     clk;
    logic                     rst;
    logic                     start_i;
    logic                     hint_i;
    logic                     key_valid_i;
    memgame_pkg::scan_code_t  key_code_i;
    logic                     key_break_i;
    memgame_pkg::rgb_t        pixel_data;
    logic                     hsync_o;
    logic                     vsync_o;
    memgame_pkg::rgb_t        rgb_o;
    memgame_pkg::pix_addr_t   pixel_addr_o;
    memgame_pkg::tile_idx_t   tile_o;
    memgame_pkg::tile_vec_t   shown_o;
    memgame_pkg::tile_vec_t   matched_o;
    memgame_pkg::game_state_t state_o;
    logic                     pass_o;

    memgame_pkg::tile_vec_t   exp_matched;
    memgame_pkg::tile_vec_t   exp_flip;
    logic [15:0]              lfsr;
    int                       order[$];
    int                       beam_h;
    int                       beam_v;
    int                       out_h;
    int                       out_v;
    int                       n;
    int                       r;
    int                       tmp;
    int                       img;

    memgame_top dut (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .hint_i       (hint_i),
        .key_valid_i  (key_valid_i),
        .key_code_i   (key_code_i),
        .key_break_i  (key_break_i),
        .pixel_data_i (pixel_data),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .rgb_o        (rgb_o),
        .pixel_addr_o (pixel_addr_o),
        .tile_o       (tile_o),
        .shown_o      (shown_o),
        .matched_o    (matched_o),
        .state_o      (state_o),
        .pass_o       (pass_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Image colour, depends on the image number and every address bit
    function automatic memgame_pkg::rgb_t colour(input int image, input int addr);
        logic [12:0] a;
        a = addr[12:0];
        return a[11:0] ^ {a[12], image[2:0], 8'h5A};
    endfunction

    // Image memory with one cycle of read latency
    always @(posedge clk) begin
        pixel_data <= colour(tile_o % memgame_pkg::NUM_PAIRS, pixel_addr_o);
    end

    // Beam position, and the pixel that rgb_o currently carries
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            beam_h <= 0;
            beam_v <= 0;
            out_h  <= memgame_pkg::H_TOTAL - 1;
            out_v  <= memgame_pkg::V_TOTAL - 1;
        end else begin
            out_h  <= beam_h;
            out_v  <= beam_v;
            beam_h <= (beam_h == memgame_pkg::H_TOTAL - 1) ? 0 : beam_h + 1;
            if (beam_h == memgame_pkg::H_TOTAL - 1) begin
                beam_v <= (beam_v == memgame_pkg::V_TOTAL - 1) ? 0 : beam_v + 1;
            end
        end
    end

    // Four tiles per grid row, each 2x2 screen pixels per source pixel
    function automatic int tile_at(input int h, input int v);
        return (v / 2 / memgame_pkg::TILE_H) * 4 + h / 2 / memgame_pkg::TILE_W;
    endfunction

    // Mirrored tiles read their rows bottom first
    function automatic int image_addr(input int h, input int v, input logic mirror);
        int x;
        int y;
        x = (h / 2) % memgame_pkg::TILE_W;
        y = (v / 2) % memgame_pkg::TILE_H;
        if (mirror) begin
            y = memgame_pkg::TILE_H - 1 - y;
        end
        return y * memgame_pkg::TILE_W + x;
    endfunction

    function automatic memgame_pkg::rgb_t expected_pixel(input int h, input int v,
                                                         input logic hint_on,
                                                         input memgame_pkg::tile_vec_t vis,
                                                         input memgame_pkg::tile_vec_t flips);
        int tile;
        tile = tile_at(h, v);
        if (hint_on || vis[tile]) begin
            return colour(tile % memgame_pkg::NUM_PAIRS,
                          image_addr(h, v, flips[tile] && !hint_on));
        end
        return '0;
    endfunction

    // Active-low pulse of len positions starting at start
    function automatic logic sync_level(input int pos, input int start, input int len);
        return !(pos >= start && pos < start + len);
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        repeat (count) begin
            value = (value << 1) | lfsr[0];
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic key_event(input memgame_pkg::scan_code_t code, input logic brk);
        @(posedge clk);
        #1;
        key_valid_i = 1'b1;
        key_code_i  = code;
        key_break_i = brk;
        @(posedge clk);
        #1;
        key_valid_i = 1'b0;
    endtask

    task automatic pair_keys(input int a, input int b);
        key_event(memgame_pkg::TILE_SCAN_CODES[a], 1'b0);
        key_event(memgame_pkg::TILE_SCAN_CODES[b], 1'b0);
        key_event(memgame_pkg::TILE_SCAN_CODES[b], 1'b1);
        key_event(memgame_pkg::TILE_SCAN_CODES[a], 1'b1);
        @(negedge clk);
    endtask

    task automatic flip_key(input int t);
        key_event(memgame_pkg::SC_SHIFT, 1'b0);
        key_event(memgame_pkg::TILE_SCAN_CODES[t], 1'b0);
        key_event(memgame_pkg::TILE_SCAN_CODES[t], 1'b1);
        key_event(memgame_pkg::SC_SHIFT, 1'b1);
        @(negedge clk);
    endtask

    task automatic enter_key();
        key_event(memgame_pkg::SC_ENTER, 1'b0);
        key_event(memgame_pkg::SC_ENTER, 1'b1);
        @(negedge clk);
        check_value("shown_o", shown_o, exp_matched);
    endtask

    task automatic press_start();
        @(posedge clk);
        #1;
        start_i = 1'b1;
        repeat (12) @(posedge clk);
        #1;
        start_i = 1'b0;
    endtask

    task automatic wait_state(input memgame_pkg::game_state_t st);
        int cycles;
        for (cycles = 0; cycles < 50 && state_o !== st; cycles++) begin
            @(negedge clk);
        end
        if (state_o !== st) report_timeout("state_o to change");
    endtask

    task automatic count_until_hsync(input logic level, output int cycles);
        for (cycles = 0; cycles < 2 * memgame_pkg::H_TOTAL && hsync_o !== level; cycles++) begin
            @(negedge clk);
        end
        if (hsync_o !== level) report_timeout("an hsync_o edge");
    endtask

    // Every beam position of one frame, with syncs, address and video
    task automatic scan_frame(input logic hint_on, input memgame_pkg::tile_vec_t vis,
                              input memgame_pkg::tile_vec_t flips);
        int cycles;
        int tile;
        @(posedge clk);
        for (cycles = 0; cycles < memgame_pkg::H_TOTAL * memgame_pkg::V_TOTAL; cycles++) begin
            @(negedge clk);
            check_value("hsync_o", hsync_o,
                        sync_level(out_h, memgame_pkg::H_DISPLAY + memgame_pkg::H_FRONT,
                                   memgame_pkg::H_SYNC));
            check_value("vsync_o", vsync_o,
                        sync_level(out_v, memgame_pkg::V_DISPLAY + memgame_pkg::V_FRONT,
                                   memgame_pkg::V_SYNC));
            if (beam_h < memgame_pkg::H_DISPLAY && beam_v < memgame_pkg::V_DISPLAY) begin
                tile = tile_at(beam_h, beam_v);
                check_value("tile_o", tile_o, tile);
                check_value("pixel_addr_o", pixel_addr_o,
                            image_addr(beam_h, beam_v, flips[tile] && !hint_on));
            end
            if (out_h < memgame_pkg::H_DISPLAY && out_v < memgame_pkg::V_DISPLAY) begin
                check_value("rgb_o", rgb_o, expected_pixel(out_h, out_v, hint_on, vis, flips));
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        start_i     = 1'b0;
        hint_i      = 1'b0;
        key_valid_i = 1'b0;
        key_code_i  = '0;
        key_break_i = 1'b0;
        pixel_data  = '0;
        lfsr        = 16'd19828;
        exp_matched = '0;
        // Tiles 0, 1, 13 and 14 start upside down
        exp_flip    = 16'b0110_0000_0000_0011;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        check_value("state_o", state_o, memgame_pkg::ST_IDLE);
        check_value("pass_o", pass_o, 1'b0);
        check_value("shown_o", shown_o, '0);
        check_value("rgb_o", rgb_o, '0);
        count_until_hsync(1'b1, n);
        count_until_hsync(1'b0, n);
        count_until_hsync(1'b1, n);
        check_value("hsync_o low time", n, memgame_pkg::H_SYNC);
        count_until_hsync(1'b0, tmp);
        check_value("hsync_o period", n + tmp, memgame_pkg::H_TOTAL);

        press_start();
        wait_state(memgame_pkg::ST_SHOW);
        check_value("shown_o", shown_o, 16'hFFFF);
        press_start();
        wait_state(memgame_pkg::ST_PLAY);
        check_value("shown_o", shown_o, '0);

        pair_keys(2, 10);
        exp_matched = 16'h0404;
        check_value("matched_o", matched_o, exp_matched);
        enter_key();
        pair_keys(3, 4);
        check_value("shown_o", shown_o, exp_matched | 16'h0018);
        check_value("matched_o", matched_o, exp_matched);
        enter_key();

        // Tile 0 is still upside down, so no match yet
        pair_keys(0, 8);
        check_value("matched_o", matched_o, exp_matched);
        enter_key();
        flip_key(0);
        exp_flip[0] = 1'b0;
        check_value("shown_o", shown_o, exp_matched | 16'h0001);
        enter_key();
        pair_keys(0, 8);
        exp_matched = exp_matched | 16'h0101;
        check_value("matched_o", matched_o, exp_matched);
        enter_key();

        @(posedge clk);
        #1;
        hint_i = 1'b1;
        pair_keys(5, 13);
        check_value("shown_o", shown_o, exp_matched);
        scan_frame(1'b1, exp_matched, exp_flip);
        @(posedge clk);
        #1;
        hint_i = 1'b0;
        scan_frame(1'b0, exp_matched, exp_flip);

        order = '{1, 3, 4, 5, 6, 7};
        for (int i = order.size() - 1; i > 0; i--) begin
            take_bits(3, r);
            r        = r % (i + 1);
            tmp      = order[i];
            order[i] = order[r];
            order[r] = tmp;
        end
        foreach (order[k]) begin
            img = order[k];
            for (int t = img; t < memgame_pkg::NUM_TILES; t += memgame_pkg::NUM_PAIRS) begin
                if (exp_flip[t]) begin
                    flip_key(t);
                    exp_flip[t] = 1'b0;
                    check_value("shown_o", shown_o, exp_matched | (16'h1 << t));
                    enter_key();
                end
            end
            pair_keys(img, img + memgame_pkg::NUM_PAIRS);
            exp_matched[img]                        = 1'b1;
            exp_matched[img + memgame_pkg::NUM_PAIRS] = 1'b1;
            check_value("matched_o", matched_o, exp_matched);
            if (exp_matched != 16'hFFFF) begin
                enter_key();
            end
        end

        for (n = 0; n < 20 && pass_o !== 1'b1; n++) begin
            @(negedge clk);
        end
        if (pass_o !== 1'b1) report_timeout("pass_o after the last match");
        check_value("state_o", state_o, memgame_pkg::ST_FINISH);
        press_start();
        wait_state(memgame_pkg::ST_IDLE);
        @(negedge clk);
        check_value("pass_o", pass_o, 1'b0);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: memgame_top.f
rtl/memgame_pkg.sv
rtl/button_pulse.sv
rtl/key_tracker.sv
rtl/board_ctrl.sv
rtl/vga_timing.sv
rtl/tile_render.sv
rtl/memgame_top.sv
tests/memgame_tb.sv
